// File: rv_core.f
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/alu.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/lsu_axil.sv
hdl/rv_core.sv
tests/tb_clock_gen.sv
tests/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// File: tests/rv_core_tb.sv
`default_nettype none

`include "rv_core_params.svh"

module rv_core_tb
    import rv_core_pkg::*;
();

    localparam word_t ECALL = 32'h0000_0073;

    logic clk, rst_n, instr_req, halted;
    addr_t instr_addr, awaddr, araddr;
    word_t instr_data, wdata, rdata;
    logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    word_t rom [256];
    word_t dmem [512];
    addr_t pc_w;
    addr_t aw_log [$]; // Every accepted write address
    string test_name;  // Program currently running
    int errors;

    tb_clock_gen u_clk (.clk(clk));

    rv_core DUT (
        .clk(clk), .rst_n(rst_n), .instr_req(instr_req), .instr_addr(instr_addr),
        .instr_data(instr_data), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb), .bvalid(bvalid),
        .bready(bready), .bresp(bresp), .arvalid(arvalid), .arready(arready),
        .araddr(araddr), .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .halted(halted)
    );

    // Instruction ROM and AXI4-Lite slave, sampled mid-cycle and driven after the edge
    initial begin
        logic s_rst_n, s_req, s_aw, s_w, s_b, s_ar, s_r, aw_have, w_have, ar_have;
        addr_t s_iaddr, s_awaddr, s_araddr, aw_addr_l, ar_addr_l;
        word_t s_wdata, w_data_l;
        logic [3:0] s_wstrb;
        int aw_wait, w_wait, ar_wait;
        void'($urandom(15));
        instr_data = '0;
        {awready, wready, arready, bvalid, rvalid} = '0;
        bresp = `AXI_RESP_OKAY;
        rresp = `AXI_RESP_OKAY;
        rdata = '0;
        {aw_have, w_have, ar_have} = '0;
        aw_wait = 0;
        w_wait = 0;
        ar_wait = 0;
        forever begin
            @(negedge clk);
            s_rst_n = rst_n;
            s_req = instr_req;
            s_iaddr = instr_addr;
            s_aw = awvalid && awready;
            s_w = wvalid && wready;
            s_b = bvalid && bready;
            s_ar = arvalid && arready;
            s_r = rvalid && rready;
            s_awaddr = awaddr;
            s_araddr = araddr;
            s_wdata = wdata;
            s_wstrb = wstrb;
            @(posedge clk);
            #1;
            if (s_req) instr_data = rom[s_iaddr[9:2]]; // Valid one cycle after the request
            if (!s_rst_n) begin
                {awready, wready, arready, bvalid, rvalid} = '0;
                {aw_have, w_have, ar_have} = '0;
                aw_log.delete();
            end else begin
                if (s_aw) begin
                    aw_have = 1'b1;
                    aw_addr_l = s_awaddr;
                    aw_log.push_back(s_awaddr);
                    awready = 1'b0;
                    aw_wait = $urandom % 4;
                end
                if (s_w) begin
                    check_strb({test_name, " wstrb"}, 4'hf, s_wstrb); // Word stores only
                    w_have = 1'b1;
                    w_data_l = s_wdata;
                    wready = 1'b0;
                    w_wait = $urandom % 4;
                end
                if (s_ar) begin
                    ar_have = 1'b1;
                    ar_addr_l = s_araddr;
                    arready = 1'b0;
                    ar_wait = $urandom % 4;
                end
                if (s_b) bvalid = 1'b0;
                if (s_r) rvalid = 1'b0;
                if (awvalid && !awready && !aw_have) begin
                    if (aw_wait == 0) awready = 1'b1;
                    else aw_wait--;
                end
                if (wvalid && !wready && !w_have) begin
                    if (w_wait == 0) wready = 1'b1;
                    else w_wait--;
                end
                if (arvalid && !arready && !ar_have) begin
                    if (ar_wait == 0) arready = 1'b1;
                    else ar_wait--;
                end
                if (aw_have && w_have && !bvalid) begin
                    dmem[aw_addr_l[10:2]] = w_data_l;
                    bvalid = 1'b1;
                    aw_have = 1'b0;
                    w_have = 1'b0;
                end
                if (ar_have && !rvalid) begin
                    rdata = dmem[ar_addr_l[10:2]];
                    rvalid = 1'b1;
                    ar_have = 1'b0;
                end
            end
        end
    end

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        errors++;
        $display("FAIL %s: expected %h, actual %h", name, exp, act);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) report_mismatch(name, exp, act);
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) report_mismatch(name, exp, act);
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) report_mismatch(name, {31'b0, exp}, {31'b0, act});
    endtask

    task automatic check_strb(input string name, input logic [3:0] exp,
                              input logic [3:0] act);
        if (exp !== act) report_mismatch(name, {28'b0, exp}, {28'b0, act});
    endtask

    // Encoders follow the RV32 base formats
    function automatic word_t op_r(input int f7, input int f3, input int rd, input int rs1,
                                   input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t op_i(input int op, input int f3, input int rd, input int rs1,
                                   input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t op_s(input int rs2, input int off, input int rs1);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic word_t op_b(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t op_u(input int op, input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t op_j(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'hA5A5_0000;
    endfunction

    function automatic word_t mem_at(input addr_t a);
        return dmem[a[10:2]];
    endfunction

    task automatic put(input word_t w);
        rom[pc_w[9:2]] = w;
        pc_w = pc_w + 32'd4;
    endtask

    task automatic load_memories();
        for (int i = 0; i < 256; i++) rom[i] = ECALL;
        for (int i = 0; i < 512; i++) dmem[i] = fill_word(addr_t'(i) << 2);
        pc_w = `RESET_PC;
    endtask

    task automatic reset_core(input string name);
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                check_flag({name, " instr_req in reset"}, 1'b0, instr_req);
                check_flag({name, " valid in reset"}, 1'b0, awvalid | wvalid | arvalid);
                check_flag({name, " halted in reset"}, 1'b0, halted);
            end
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic run_program(input string name);
        int cycles;
        cycles = 0;
        test_name = name;
        reset_core(name);
        while (!halted) begin
            if (cycles > 3000) begin
                $display("Timeout in %s: core never halted, state %s", name, DUT.state_q.name());
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic test_reset_halt();
        load_memories();
        run_program("reset_halt");
        repeat (4) @(negedge clk); // Core must stay parked until reset
        check_flag("reset_halt halted", 1'b1, halted);
        check_flag("reset_halt instr_req", 1'b0, instr_req);
        check_word("reset_halt writes", 32'd0, aw_log.size());
        check_addr("reset_halt pc", `RESET_PC, instr_addr);
    endtask

    task automatic test_arith();
        word_t a, b, exp[10];
        addr_t auipc_pc;
        a = 32'h1234_5678;
        b = 32'hFFFF_FEDD;
        load_memories();
        put(op_i(7'h13, 0, 10, 0, 32'h100));
        put(op_u(7'h37, 1, 32'h12345));
        put(op_i(7'h13, 0, 1, 1, 32'h678));
        put(op_i(7'h13, 0, 2, 0, -291));
        put(op_r(0, 0, 3, 1, 2));
        put(op_r(7'h20, 0, 4, 1, 2));
        put(op_r(1, 0, 5, 1, 2));
        put(op_r(0, 7, 6, 1, 2));
        put(op_r(0, 6, 7, 1, 2));
        put(op_i(7'h13, 0, 8, 1, 32'h7ff));
        put(op_i(7'h13, 1, 9, 1, 5));
        put(op_i(7'h13, 5, 11, 2, 7));
        put(op_u(7'h37, 12, 32'hABCDE));
        auipc_pc = pc_w;
        put(op_u(7'h17, 13, 1));
        foreach (exp[i]) put(op_s((i < 7) ? i + 3 : i + 4, 4 * i, 10));
        put(ECALL);
        exp = '{a + b, a - b, a * b, a & b, a | b, a + 32'h7ff, a << 5, b >> 7,
                32'hABCD_E000, auipc_pc + 32'h1000};
        run_program("arith");
        foreach (exp[i]) check_word($sformatf("arith[%0d]", i), exp[i], mem_at(32'h100 + 4 * i));
    endtask

    task automatic test_branches();
        word_t exp[9];
        addr_t jal_pc;
        load_memories();
        put(op_i(7'h13, 0, 10, 0, 32'h200));
        put(op_i(7'h13, 0, 1, 0, -5));
        put(op_i(7'h13, 0, 2, 0, 3));
        put(op_i(7'h13, 0, 20, 0, 32'h55));
        put(op_i(7'h13, 0, 21, 0, 32'h66));
        put(op_b(0, 1, 1, 8));  // BEQ taken
        put(op_s(20, 0, 10));
        put(op_b(0, 1, 2, 8));  // BEQ falls through
        put(op_s(20, 4, 10));
        put(op_b(1, 1, 2, 8));  // BNE taken
        put(op_s(20, 8, 10));
        put(op_b(4, 1, 2, 8));  // -5 < 3
        put(op_s(20, 12, 10));
        put(op_b(4, 2, 1, 8));
        put(op_s(21, 16, 10));
        put(op_b(5, 2, 1, 8));  // 3 >= -5
        put(op_s(20, 20, 10));
        put(op_b(5, 1, 2, 8));
        put(op_s(21, 24, 10));
        jal_pc = pc_w;
        put(op_j(5, 8));
        put(op_s(20, 28, 10));
        put(op_s(5, 32, 10));
        put(ECALL);
        exp = '{fill_word(32'h200), 32'h55, fill_word(32'h208), fill_word(32'h20C), 32'h66,
                fill_word(32'h214), 32'h66, fill_word(32'h21C), jal_pc + 32'd4};
        run_program("branches");
        foreach (exp[i]) check_word($sformatf("branches[%0d]", i), exp[i],
                                    mem_at(32'h200 + 4 * i));
        check_word("branches writes", 32'd4, aw_log.size());
    endtask

    task automatic test_load_store();
        addr_t exp_aw[5];
        load_memories();
        put(op_i(7'h13, 0, 10, 0, 32'h300));
        put(op_i(7'h13, 0, 11, 0, 32'h340));
        put(op_i(7'h13, 0, 1, 0, 32'h111));
        put(op_i(7'h13, 0, 2, 0, -2));
        put(op_s(1, 0, 10));
        put(op_s(2, 8, 10));
        put(op_i(7'h03, 2, 3, 10, 0));
        put(op_i(7'h03, 2, 4, 10, 8));
        put(op_r(0, 0, 5, 3, 4));
        put(op_s(5, -16, 11));
        put(op_i(7'h03, 2, 6, 11, -16));
        put(op_i(7'h13, 1, 7, 6, 1));
        put(op_s(7, 4, 10));
        put(op_i(7'h03, 2, 8, 11, 0)); // Untouched word from the fill pattern
        put(op_s(8, 4, 11));
        put(ECALL);
        exp_aw = '{32'h300, 32'h308, 32'h340 - 32'd16, 32'h304, 32'h344};
        run_program("load_store");
        check_word("load_store writes", 32'd5, aw_log.size());
        foreach (exp_aw[i]) check_addr($sformatf("load_store awaddr[%0d]", i), exp_aw[i],
                                       aw_log[i]);
        check_word("load_store 0x300", 32'h111, mem_at(32'h300));
        check_word("load_store 0x308", 32'hFFFF_FFFE, mem_at(32'h308));
        check_word("load_store 0x330", 32'h111 + 32'hFFFF_FFFE, mem_at(32'h330));
        check_word("load_store 0x304", (32'h111 + 32'hFFFF_FFFE) << 1, mem_at(32'h304));
        check_word("load_store 0x344", fill_word(32'h340), mem_at(32'h344));
    endtask

    task automatic test_x0();
        load_memories();
        put(op_i(7'h13, 0, 10, 0, 32'h400));
        put(op_i(7'h13, 0, 0, 0, 32'h123));
        put(op_s(0, 0, 10));
        put(ECALL);
        run_program("x0");
        check_word("x0 store", 32'd0, mem_at(32'h400));
    endtask

    initial begin
        errors = 0;
        rst_n = 1'b0;
        test_reset_halt();
        test_arith();
        test_branches();
        test_load_store();
        test_x0();
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk; // 10 unit period

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`default_nettype none

`include "rv_core_params.svh"

module rv_core
    import rv_core_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    output logic       instr_req,
    output addr_t      instr_addr,
    input  wire word_t instr_data,
    output logic       awvalid,
    input  wire logic  awready,
    output addr_t      awaddr,
    output logic       wvalid,
    input  wire logic  wready,
    output word_t      wdata,
    output logic [3:0] wstrb,
    input  wire logic  bvalid,
    output logic       bready,
    input  wire logic [1:0] bresp,
    output logic       arvalid,
    input  wire logic  arready,
    output addr_t      araddr,
    input  wire logic  rvalid,
    output logic       rready,
    input  wire word_t rdata,
    input  wire logic [1:0] rresp,
    output logic       halted
);

    core_state_e state_q;
    core_state_e state_d;
    addr_t       pc_q;
    word_t       ir_q;
    word_t       instr_word;
    ctrl_t       ctrl;
    word_t       immediate;
    word_t       rs1_data;
    word_t       rs2_data;
    alu_res_t    alu_res;
    addr_t       pc_plus4;
    word_t       wb_data;
    logic        lsu_req;
    logic        lsu_done;
    word_t       load_data;

    // Fetched word is decoded straight from the port during ST_EXEC
    assign instr_word = (state_q == ST_EXEC) ? instr_data : ir_q;
    assign instr_addr = pc_q;
    assign pc_plus4   = pc_q + 32'd4;
    assign halted     = (state_q == ST_HALT);
    assign lsu_req    = (state_q == ST_EXEC) && (ctrl.mem_read || ctrl.mem_write);

    always_comb begin
        if (ctrl.is_jump) begin
            wb_data = pc_plus4; // Link value
        end else if (ctrl.mem_read) begin
            wb_data = load_data;
        end else begin
            wb_data = alu_res.result;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_FETCH: if (instr_req) state_d = ST_EXEC;
            ST_EXEC: begin
                if (ctrl.is_halt || ctrl.illegal) begin
                    state_d = ST_HALT;
                end else if (ctrl.mem_read || ctrl.mem_write) begin
                    state_d = ST_MEM;
                end else begin
                    state_d = ST_WB;
                end
            end
            ST_MEM:  if (lsu_done) state_d = ST_WB;
            ST_WB:   state_d = ST_FETCH;
            ST_HALT: state_d = ST_HALT; // Until reset
            default: state_d = ST_HALT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= ST_FETCH;
            pc_q      <= `RESET_PC;
            instr_req <= 1'b0;
        end else begin
            state_q   <= state_d;
            instr_req <= (state_d == ST_FETCH); // High for the whole fetch cycle
            if (state_q == ST_WB) begin
                pc_q <= alu_res.branch_taken ? alu_res.target : pc_plus4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_EXEC) begin
            ir_q <= instr_data;
        end
    end

    decoder u_decoder (
        .instr     (instr_word),
        .ctrl      (ctrl),
        .immediate (immediate)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (ctrl.rs1),
        .rs2     (ctrl.rs2),
        .rd      (ctrl.rd),
        .wr_en   ((state_q == ST_WB) && ctrl.reg_write),
        .wr_data (wb_data),
        .rd1     (rs1_data),
        .rd2     (rs2_data)
    );

    alu u_alu (
        .ctrl      (ctrl),
        .operand1  (rs1_data),
        .operand2  (rs2_data),
        .immediate (immediate),
        .pc        (pc_q),
        .res       (alu_res)
    );

    lsu_axil u_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (lsu_req),
        .write      (ctrl.mem_write),
        .addr       (alu_res.result),
        .store_data (rs2_data),
        .done       (lsu_done),
        .rdata_out  (load_data),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp)
    );

    // A halted core stays silent on both ports
    assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !(instr_req || awvalid || wvalid || arvalid))
        else $error("rv_core: bus activity after halt");

endmodule

`default_nettype wire

// File: hdl/lsu_axil.sv
`default_nettype none

`include "rv_core_params.svh"

module lsu_axil
    import rv_core_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  req,
    input  wire logic  write,
    input  wire addr_t addr,
    input  wire word_t store_data,
    output logic       done,
    output word_t      rdata_out,
    output logic       awvalid,
    input  wire logic  awready,
    output addr_t      awaddr,
    output logic       wvalid,
    input  wire logic  wready,
    output word_t      wdata,
    output logic [3:0] wstrb,
    input  wire logic  bvalid,
    output logic       bready,
    input  wire logic [1:0] bresp,
    output logic       arvalid,
    input  wire logic  arready,
    output addr_t      araddr,
    input  wire logic  rvalid,
    output logic       rready,
    input  wire word_t rdata,
    input  wire logic [1:0] rresp
);

    lsu_state_e state_q;
    logic       wr_q;      // Current request is a store
    logic       aw_done_q;
    logic       w_done_q;
    addr_t      addr_q;
    word_t      wdata_q;
    logic       aw_fire;
    logic       w_fire;
    logic       b_fire;
    logic       ar_fire;
    logic       r_fire;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    assign awaddr = addr_q;
    assign araddr = addr_q;
    assign wdata  = wdata_q;
    assign wstrb  = 4'hf; // Word accesses only

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= LSU_IDLE;
            wr_q      <= 1'b0;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            arvalid   <= 1'b0;
            bready    <= 1'b0;
            rready    <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                LSU_IDLE: begin
                    if (req) begin
                        wr_q      <= write;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        awvalid   <= write; // AW and W raised together
                        wvalid    <= write;
                        arvalid   <= !write;
                        state_q   <= LSU_ADDR;
                    end
                end
                LSU_ADDR: begin
                    if (wr_q) begin
                        if (aw_fire) begin
                            awvalid   <= 1'b0;
                            aw_done_q <= 1'b1;
                        end
                        if (w_fire) begin
                            wvalid   <= 1'b0;
                            w_done_q <= 1'b1;
                        end
                        if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
                            bready  <= 1'b1;
                            state_q <= LSU_RESP;
                        end
                    end else if (ar_fire) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state_q <= LSU_RESP;
                    end
                end
                LSU_RESP: begin
                    if (wr_q && b_fire) begin
                        bready  <= 1'b0;
                        done    <= 1'b1;
                        state_q <= LSU_IDLE;
                    end else if (!wr_q && r_fire) begin
                        rready  <= 1'b0;
                        done    <= 1'b1;
                        state_q <= LSU_IDLE;
                    end
                end
                default: state_q <= LSU_IDLE;
            endcase
        end
    end

    // Request payload and load data
    always_ff @(posedge clk) begin
        if (state_q == LSU_IDLE && req) begin
            addr_q  <= addr;
            wdata_q <= store_data;
        end
        if (r_fire) begin
            rdata_out <= rdata;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> $stable(awaddr))
        else $error("lsu_axil: awaddr changed before the AW handshake");

    // Error responses are accepted and otherwise ignored
    cover property (@(posedge clk) disable iff (!rst_n)
        (b_fire && bresp != `AXI_RESP_OKAY) || (r_fire && rresp != `AXI_RESP_OKAY));

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

`include "rv_core_params.svh"

module reg_file
    import rv_core_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    input  wire reg_idx_t rd,
    input  wire logic     wr_en,
    input  wire word_t    wr_data,
    output word_t         rd1,
    output word_t         rd2
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd != '0) begin // x0 is never written
            regs[rd] <= wr_data;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    // x0 storage must stay zero whatever the core asks for
    assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("reg_file: x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: hdl/decoder.sv
`default_nettype none

module decoder
    import rv_core_pkg::*;
(
    input  wire word_t instr,
    output ctrl_t      ctrl,
    output word_t      immediate
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl         = '0;
        ctrl.opcode  = opcode_e'(instr[6:0]);
        ctrl.rd      = instr[11:7];
        ctrl.funct3  = instr[14:12];
        ctrl.rs1     = instr[19:15];
        ctrl.rs2     = instr[24:20];
        ctrl.funct7  = instr[31:25];
        ctrl.illegal = 1'b1; // Cleared by each legal encoding
        immediate    = '0;
        case (ctrl.opcode)
            OP_REG: begin
                if ((ctrl.funct7 == 7'b0000000 && ctrl.funct3 inside {3'b000, 3'b110, 3'b111}) ||
                    (ctrl.funct7 == 7'b0100000 && ctrl.funct3 == 3'b000) ||
                    (ctrl.funct7 == 7'b0000001 && ctrl.funct3 == 3'b000)) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.illegal   = 1'b0;
                end
            end
            OP_IMM: begin
                immediate = imm_i;
                if (ctrl.funct3 == 3'b000 ||
                    (ctrl.funct3 inside {3'b001, 3'b101} && ctrl.funct7 == 7'b0000000)) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.illegal   = 1'b0;
                end
            end
            OP_LUI, OP_AUIPC: begin
                immediate      = imm_u;
                ctrl.reg_write = 1'b1;
                ctrl.illegal   = 1'b0;
            end
            OP_BRANCH: begin
                immediate    = imm_b;
                ctrl.illegal = !(ctrl.funct3 inside {3'b000, 3'b001, 3'b100, 3'b101});
            end
            OP_JAL: begin
                immediate      = imm_j;
                ctrl.reg_write = 1'b1;
                ctrl.is_jump   = 1'b1;
                ctrl.illegal   = 1'b0;
            end
            OP_LOAD: begin
                immediate = imm_i;
                if (ctrl.funct3 == 3'b010) begin // LW only
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.illegal   = 1'b0;
                end
            end
            OP_STORE: begin
                immediate = imm_s;
                if (ctrl.funct3 == 3'b010) begin // SW only
                    ctrl.mem_write = 1'b1;
                    ctrl.illegal   = 1'b0;
                end
            end
            OP_SYSTEM: begin
                if (instr[31:7] == '0) begin // ECALL
                    ctrl.is_halt = 1'b1;
                    ctrl.illegal = 1'b0;
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/alu.sv
`default_nettype none

module alu
    import rv_core_pkg::*;
(
    input  wire ctrl_t    ctrl,
    input  wire word_t    operand1,
    input  wire word_t    operand2,
    input  wire word_t    immediate,
    input  wire addr_t    pc,
    output alu_res_t      res
);

    always_comb begin
        res.result       = '0;
        res.target       = pc + immediate; // Branch and JAL destination
        res.branch_taken = 1'b0;
        case (ctrl.opcode)
            OP_REG: begin
                case (ctrl.funct7)
                    7'b0100000: res.result = operand1 - operand2; // SUB
                    7'b0000001: res.result = operand1 * operand2; // MUL, low 32 bits
                    7'b0000000: begin
                        case (ctrl.funct3)
                            3'b000:  res.result = operand1 + operand2; // ADD
                            3'b111:  res.result = operand1 & operand2; // AND
                            3'b110:  res.result = operand1 | operand2; // OR
                            default: res.result = '0;
                        endcase
                    end
                    default: res.result = '0;
                endcase
            end
            OP_IMM: begin
                case (ctrl.funct3)
                    3'b000:  res.result = operand1 + immediate;       // ADDI
                    3'b001:  res.result = operand1 << immediate[4:0]; // SLLI
                    3'b101:  res.result = operand1 >> immediate[4:0]; // SRLI
                    default: res.result = '0;
                endcase
            end
            OP_AUIPC: res.result = res.target;
            OP_LUI:   res.result = immediate; // Already shifted by the decoder
            OP_BRANCH: begin
                res.result = operand1 - operand2;
                case (ctrl.funct3)
                    3'b000:  res.branch_taken = (operand1 == operand2);                   // BEQ
                    3'b001:  res.branch_taken = (operand1 != operand2);                   // BNE
                    3'b100:  res.branch_taken = ($signed(operand1) < $signed(operand2));  // BLT
                    3'b101:  res.branch_taken = ($signed(operand1) >= $signed(operand2)); // BGE
                    default: res.branch_taken = 1'b0;
                endcase
            end
            OP_JAL:   res.branch_taken = 1'b1; // Unconditional
            OP_LOAD:  res.result = operand1 + immediate; // Effective address
            OP_STORE: res.result = operand1 + immediate;
            default:  res.result = '0;
        endcase
    end

    // Only control transfers may redirect the PC
    always_comb begin
        assert final (!res.branch_taken || ctrl.opcode inside {OP_BRANCH, OP_JAL})
            else $error("alu: branch_taken set for opcode %b", ctrl.opcode);
    end

endmodule

`default_nettype wire

// File: hdl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;    // Data word
    typedef logic [31:0] addr_t;    // Byte address, PC and data memory
    typedef logic [4:0]  reg_idx_t; // Register file index

    // RV32 major opcodes kept by the core
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       reg_write; // Writes rd in ST_WB
        logic       mem_read;
        logic       mem_write;
        logic       is_jump;   // JAL, link is PC+4
        logic       is_halt;   // ECALL
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        word_t result;
        addr_t target;       // Always pc + immediate
        logic  branch_taken;
    } alu_res_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_WB,
        ST_HALT
    } core_state_e;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_ADDR, // AW/W or AR outstanding
        LSU_RESP  // Waiting for B or R
    } lsu_state_e;

endpackage

`default_nettype wire

// File: hdl/rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Integer register count, x0 included
`define NUM_REGS 32

// AXI4-Lite response codes
`define AXI_RESP_OKAY 2'b00

`endif
